// File: sched_pkg.sv
package sched_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int DEPTH_W    = 8;                // Bits of one queue depth counter
  localparam int PORT_IDX_W = 4;                // Bits of a port number, so 16 ports at most
  localparam int BURST_W    = 4;                // Bits of a burst length

  // --------------------
  // Scalar types
  // --------------------
  typedef logic [DEPTH_W-1:0]    depth_t;       // Number of items waiting in one queue
  typedef logic [PORT_IDX_W-1:0] port_idx_t;    // Index of one input port
  typedef logic [BURST_W-1:0]    burst_t;       // Serve strobes in one grant

  // --------------------
  // Pick result
  // --------------------
  // The tree output travels to the grant machine as one bundle
  typedef struct packed {
    logic      valid;                           // Set when some port holds work
    port_idx_t port;                            // Deepest port, lowest index on a tie
    depth_t    depth;                           // Depth of that port
  } pick_t;

  // --------------------
  // Grant machine
  // --------------------
  typedef enum logic {
    ST_IDLE  = 1'b0,                            // Waiting for a valid pick
    ST_SERVE = 1'b1                             // Issuing serve strobes for one burst
  } grant_state_t;

endpackage

// File: max_finder_tree.sv
`timescale 1ns/1ps

module max_finder_tree #(
  parameter int PORT_COUNT = 8
) (
  input  sched_pkg::depth_t [PORT_COUNT-1:0] depths,
  input  logic              [PORT_COUNT-1:0] valids,
  output sched_pkg::pick_t                   pick
);
  import sched_pkg::*;

  // A single port still needs a two-leaf tree
  localparam int CEIL_PORT_CNT = (PORT_COUNT < 2) ? 2 : 2 ** $clog2(PORT_COUNT);

  depth_t [CEIL_PORT_CNT-1:0] padded;           // Masked depths plus zero padding
  depth_t                     max_val;          // Largest depth out of the tree
  port_idx_t                  max_ptr;          // Where that depth was found

  // --------------------
  // Mask and pad
  // --------------------
  always_comb begin
    padded = '0;                                // Pad entries above PORT_COUNT stay zero
    for (int i = 0; i < PORT_COUNT; i++) begin
      padded[i] = valids[i] ? depths[i] : '0;   // Invalid ports never win
    end
  end

  max_finder_tree_pow_of_2 #(
    .PORT_COUNT (CEIL_PORT_CNT)
  ) u_tree (
    .values  (padded),
    .max_val (max_val),
    .max_ptr (max_ptr)
  );

  // Zero padding keeps the padded ports out of the valid term
  assign pick = '{valid: (padded != '0), port: max_ptr, depth: max_val};

endmodule

module max_finder_tree_pow_of_2 #(
  parameter int PORT_COUNT = 16
) (
  input  sched_pkg::depth_t [PORT_COUNT-1:0] values,
  output sched_pkg::depth_t                  max_val,
  output sched_pkg::port_idx_t               max_ptr
);
  import sched_pkg::*;

  localparam int LEVELS = $clog2(PORT_COUNT);   // Comparator stages from leaves to root
  localparam int NODES  = 2 * PORT_COUNT - 1;   // Leaves and comparators in heap order

  // Node n has children 2n+1 (lower ports) and 2n+2 (upper ports)
  depth_t    node_val  [NODES];                 // Winning depth at each node
  port_idx_t node_ptr  [PORT_COUNT-1];          // Index bits gathered so far per comparator
  logic      upper_win [PORT_COUNT-1];          // Comparator result per node

  genvar k, lvl, j;
  generate
    for (k = 0; k < PORT_COUNT; k++) begin : g_leaf
      assign node_val[PORT_COUNT-1+k] = values[k];   // Leaves sit at the bottom row in order
    end

    for (lvl = 0; lvl < LEVELS; lvl++) begin : g_level
      localparam int HEIGHT = LEVELS - lvl;     // Index bits this row resolves
      for (j = 0; j < 2 ** lvl; j++) begin : g_node
        localparam int N  = 2 ** lvl - 1 + j;
        localparam int LO = 2 * N + 1;
        localparam int HI = 2 * N + 2;

        // Upper half takes over only on a strict win so ties fall to the lower index
        assign upper_win[N] = node_val[HI] > node_val[LO];
        assign node_val[N]  = upper_win[N] ? node_val[HI] : node_val[LO];

        if (HEIGHT == 1) begin : g_first
          assign node_ptr[N] = port_idx_t'(upper_win[N]);   // First bit of the index
        end else begin : g_join
          // Put the new bit on top of the winner's lower bits
          assign node_ptr[N] = upper_win[N] ?
                               port_idx_t'({1'b1, node_ptr[HI][HEIGHT-2:0]}) :
                               port_idx_t'({1'b0, node_ptr[LO][HEIGHT-2:0]});
        end
      end
    end
  endgenerate

  assign max_val = node_val[0];                 // Root holds the overall maximum
  assign max_ptr = node_ptr[0];

endmodule

// File: queue_depth_table.sv
`timescale 1ns/1ps

module queue_depth_table #(
  parameter int PORT_COUNT = 8
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic              [PORT_COUNT-1:0] arrive,
  input  logic                               serve,
  input  sched_pkg::port_idx_t               serve_port,
  output sched_pkg::depth_t [PORT_COUNT-1:0] depths,
  output logic              [PORT_COUNT-1:0] valids
);
  import sched_pkg::*;

  logic   [PORT_COUNT-1:0] add_one;             // Accepted arrivals this cycle
  logic   [PORT_COUNT-1:0] sub_one;             // Serve aimed at each port
  depth_t [PORT_COUNT-1:0] depth_d;             // Next value of every counter

  // --------------------
  // Counter update
  // --------------------
  always_comb begin
    for (int i = 0; i < PORT_COUNT; i++) begin
      add_one[i] = arrive[i] && (depths[i] != '1);   // Saturated queue drops the arrival
      sub_one[i] = serve && (serve_port == port_idx_t'(i));
    end
  end

  always_comb begin
    depth_d = depths;
    for (int i = 0; i < PORT_COUNT; i++) begin
      case ({add_one[i], sub_one[i]})
        2'b10:   depth_d[i] = depths[i] + 1'b1; // Arrival only
        2'b01:   depth_d[i] = depths[i] - 1'b1; // Serve only
        default: depth_d[i] = depths[i];        // Neither, or both cancel out
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      depths <= '0;                             // All queues start empty
    end else begin
      depths <= depth_d;
    end
  end

  // --------------------
  // Occupancy flags
  // --------------------
  always_comb begin
    for (int i = 0; i < PORT_COUNT; i++) begin
      valids[i] = (depths[i] != '0);            // Taken from the registered count
    end
  end

endmodule

// File: slot_timer.sv
`timescale 1ns/1ps

module slot_timer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              load,
  input  sched_pkg::burst_t load_len,
  input  logic              run,
  output logic              last
);
  import sched_pkg::*;

  burst_t remain;                               // Serve slots still owed in this burst

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      remain <= '0;
    end else if (load) begin
      remain <= load_len;                       // Start of a new burst
    end else if (run && (remain != '0)) begin
      remain <= remain - 1'b1;                  // One slot used
    end
  end

  // With L slots loaded the count reaches one on the L-th run cycle
  assign last = run && (remain == burst_t'(1));

endmodule

// File: grant_fsm.sv
`timescale 1ns/1ps

module grant_fsm #(
  parameter int BURST_MAX = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  sched_pkg::pick_t     pick,
  input  logic                 timer_last,
  output logic                 timer_load,
  output sched_pkg::burst_t    timer_len,
  output logic                 timer_run,
  output logic                 serve,
  output sched_pkg::port_idx_t serve_port,
  output logic                 busy
);
  import sched_pkg::*;

  grant_state_t state_q;                        // Current state
  grant_state_t state_d;                        // State after this edge
  port_idx_t    port_q;                         // Port owning the running burst

  // --------------------
  // Burst length
  // --------------------
  // A deep queue is cut to BURST_MAX, a shallow one is drained completely
  always_comb begin
    if (pick.depth > depth_t'(BURST_MAX)) begin
      timer_len = burst_t'(BURST_MAX);
    end else begin
      timer_len = pick.depth[BURST_W-1:0];      // Fits since it is at most BURST_MAX
    end
  end

  // --------------------
  // Next state
  // --------------------
  always_comb begin
    state_d    = state_q;
    timer_load = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (pick.valid) begin
          timer_load = 1'b1;                    // Timer takes the length on this edge
          state_d    = ST_SERVE;
        end
      end
      ST_SERVE: begin
        if (timer_last) begin
          state_d = ST_IDLE;                    // Last serve of the burst is in this cycle
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      port_q  <= '0;                            // Serve port reads zero out of reset
    end else begin
      state_q <= state_d;
      if (timer_load) begin
        port_q <= pick.port;                    // Held for the whole burst
      end
    end
  end

  // Every cycle in ST_SERVE is one serve slot
  assign serve      = (state_q == ST_SERVE);
  assign timer_run  = serve;                    // Timer counts the same slots
  assign busy       = serve;
  assign serve_port = port_q;

endmodule

// File: sched_top.sv
`timescale 1ns/1ps

module sched_top #(
  parameter int PORT_COUNT = 8,
  parameter int BURST_MAX  = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [PORT_COUNT-1:0] arrive,
  output logic                  serve,
  output sched_pkg::port_idx_t  serve_port,
  output logic                  busy
);
  import sched_pkg::*;

  depth_t [PORT_COUNT-1:0] depths;              // Registered queue depths
  logic   [PORT_COUNT-1:0] valids;              // Nonzero depth flags
  pick_t                   pick;                // Combinational tree result
  logic                    timer_load;          // Burst start strobe
  burst_t                  timer_len;           // Length of the burst being started
  logic                    timer_run;           // High for every serve slot
  logic                    timer_last;          // Final slot of the burst

  // --------------------
  // Datapath
  // --------------------
  queue_depth_table #(
    .PORT_COUNT (PORT_COUNT)
  ) u_depth_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .arrive     (arrive),
    .serve      (serve),
    .serve_port (serve_port),
    .depths     (depths),
    .valids     (valids)
  );

  max_finder_tree #(
    .PORT_COUNT (PORT_COUNT)
  ) u_max_finder (
    .depths (depths),
    .valids (valids),
    .pick   (pick)
  );

  // --------------------
  // Control
  // --------------------
  slot_timer u_slot_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (timer_load),
    .load_len (timer_len),
    .run      (timer_run),
    .last     (timer_last)
  );

  grant_fsm #(
    .BURST_MAX (BURST_MAX)
  ) u_grant_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .pick       (pick),
    .timer_last (timer_last),
    .timer_load (timer_load),
    .timer_len  (timer_len),
    .timer_run  (timer_run),
    .serve      (serve),
    .serve_port (serve_port),
    .busy       (busy)
  );

endmodule

// File: sched_tb.sv
`timescale 1ns/1ps

module sched_tb;
  import sched_pkg::*;

  localparam int PORT_COUNT  = 6;
  localparam int BURST_MAX   = 4;
  localparam int DRAIN_LIMIT = 8000;            // Cycles allowed for the queues to empty
  localparam int QUIET_LEN   = 8;               // Idle cycles that mark the end of serving
  localparam int RAND_CYCLES = 400;

  logic                  clk;
  logic                  rst_n;
  logic [PORT_COUNT-1:0] arrive;
  logic                  serve;
  port_idx_t             serve_port;
  logic                  busy;

  depth_t    model [PORT_COUNT];                // Scoreboard copy of every queue depth
  int        errors;
  int        accepted;                          // Arrivals the model let in
  int        served;
  int        bursts;
  logic      prev_serve;
  logic      prev_valid;                        // Model had work in the previous cycle
  port_idx_t prev_pick;                         // Model's deepest port in the previous cycle
  depth_t    prev_depth;
  port_idx_t burst_port;
  int        run_len;
  int        exp_len;
  integer    seed;

  sched_top #(
    .PORT_COUNT (PORT_COUNT),
    .BURST_MAX  (BURST_MAX)
  ) dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .arrive     (arrive),
    .serve      (serve),
    .serve_port (serve_port),
    .busy       (busy)
  );

  always #2 clk = ~clk;                         // 4 ns period

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
      errors++;
    end
  endtask

  // Holds one arrive mask for a number of cycles, then leaves the inputs quiet
  task automatic apply_pattern(input logic [PORT_COUNT-1:0] mask, input int hold,
                               input int gap);
    repeat (hold) begin
      @(posedge clk);
      #0.5 arrive = mask;
    end
    repeat (gap) begin
      @(posedge clk);
      #0.5 arrive = '0;
    end
  endtask

  // --------------------
  // Scoreboard
  // --------------------
  always @(negedge clk) begin
    int   best;
    logic any;
    logic acc;
    logic sub;
    if (!rst_n) begin
      check_value(serve, 1'b0, "serve high during reset");
      check_value(busy, 1'b0, "busy high during reset");
      check_value(serve_port, '0, "serve_port nonzero during reset");
      prev_serve = 1'b0;
      prev_valid = 1'b0;
      run_len    = 0;
    end else begin
      check_value(busy, serve, "busy differs from serve");
      if (serve) begin
        check_value(serve_port < PORT_COUNT, 1'b1, "serve_port beyond the last port");
        if (serve_port < PORT_COUNT) begin
          check_value(model[serve_port] != '0, 1'b1, "serve aimed at an empty queue");
        end
        if (!prev_serve) begin                  // First slot of a new burst
          check_value(prev_valid, 1'b1, "burst started with no work queued");
          check_value(serve_port, prev_pick, "burst port is not the deepest queue");
          exp_len    = (prev_depth > BURST_MAX) ? BURST_MAX : int'(prev_depth);
          burst_port = serve_port;
          run_len    = 1;
          bursts++;
        end else begin
          run_len++;
          check_value(serve_port, burst_port, "serve_port changed inside a burst");
          if (run_len == exp_len + 1) begin
            check_value(run_len, exp_len, "burst ran past its length");
          end
        end
      end else if (prev_serve) begin
        check_value(run_len, exp_len, "burst length");
      end

      // Deepest model queue in this cycle where a tie goes to the lowest index
      best = 0;
      any  = 1'b0;
      for (int i = 0; i < PORT_COUNT; i++) begin
        if (model[i] != '0) any = 1'b1;
        if (model[i] > model[best]) best = i;
      end
      prev_valid = any;
      prev_pick  = port_idx_t'(best);
      prev_depth = model[best];

      // Arrivals add one unless the queue is full and a serve takes one away
      for (int i = 0; i < PORT_COUNT; i++) begin
        acc = arrive[i] && (model[i] != '1);
        sub = serve && (serve_port == port_idx_t'(i));
        if (acc && !sub) model[i] = model[i] + 1'b1;
        else if (sub && !acc) model[i] = model[i] - 1'b1;
        if (acc) accepted++;
      end
      if (serve) served++;
      prev_serve = serve;
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    int                    fd;
    int                    n;
    int                    hold;
    int                    gap;
    int                    patterns;
    int                    quiet;
    int                    cycles;
    logic [PORT_COUNT-1:0] mask;
    string                 line;
    clk      = 1'b0;
    rst_n    = 1'b0;
    arrive   = '0;
    errors   = 0;
    accepted = 0;
    served   = 0;
    bursts   = 0;
    patterns = 0;
    seed     = 68279;
    for (int i = 0; i < PORT_COUNT; i++) model[i] = '0;
    repeat (4) @(posedge clk);
    #0.5 rst_n = 1'b1;

    fd = $fopen("sched_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open sched_vectors.txt for reading");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#") begin   // Skip comments and blanks
          if ($sscanf(line, "%h %h %h", mask, hold, gap) == 3) begin
            apply_pattern(mask, hold, gap);
            patterns++;
          end
        end
      end
      $fclose(fd);
      if (patterns == 0) begin
        $display("No arrival patterns were read from sched_vectors.txt");
        errors++;
      end
    end

    // Sparse random arrivals, about one bit in eight set
    repeat (RAND_CYCLES) begin
      @(posedge clk);
      #0.5 arrive = PORT_COUNT'($random(seed) & $random(seed) & $random(seed));
    end
    @(posedge clk);
    #0.5 arrive = '0;

    // Drain until serving has stopped for a while
    quiet  = 0;
    cycles = 0;
    while (quiet < QUIET_LEN && cycles < DRAIN_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (serve) quiet = 0;
      else quiet++;
    end
    if (quiet < QUIET_LEN) begin
      $display("Timeout: serve strobes did not stop within %0d cycles", DRAIN_LIMIT);
      errors++;
    end
    @(posedge clk);

    check_value(served, accepted, "total serves against accepted arrivals");
    for (int i = 0; i < PORT_COUNT; i++) begin
      check_value(model[i], '0, $sformatf("model depth of port %0d after drain", i));
    end

    $display("Errors: %0d, bursts: %0d, serves: %0d, accepted arrivals: %0d",
             errors, bursts, served, accepted);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: sched_vectors.txt
# Columns: arrive mask, hold cycles, idle gap cycles, all in hex
# Six ports, so a mask uses bits 5 down to 0
01 01 08
02 03 0a
04 06 10
30 02 0c
20 05 10
10 03 00
20 03 10
3f 01 14
0c 04 14
21 08 18
3f 10 40
01 20 00
08 0c 30
18 06 00
30 06 20
3f 1c0 100
2a 20 40
15 20 40
01 03 00
3e 01 20
10 120 200
20 08 10

// File: verilog.f
sched_pkg.sv
max_finder_tree.sv
queue_depth_table.sv
slot_timer.sv
grant_fsm.sv
sched_top.sv
sched_tb.sv

// File: Bender.yml
package:
  name: sched

sources:
  - sched_pkg.sv
  - max_finder_tree.sv
  - queue_depth_table.sv
  - slot_timer.sv
  - grant_fsm.sv
  - sched_top.sv
  - target: simulation
    files:
      - sched_tb.sv
